// ==== rtl/mac_defines.svh ====
`ifndef MAC_DEFINES_SVH
`define MAC_DEFINES_SVH

// operand and result word width
`define MAC_DATA_W 32

// op code width, matches the 3-bit decode
`define MAC_OP_W 3

`endif

// ==== rtl/mac_pkg.sv ====
`default_nettype none

`include "mac_defines.svh"

package mac_pkg;

  // op codes, 011 left unused on purpose
  typedef enum logic [`MAC_OP_W-1:0] {
    OP_ADD   = 3'b000,
    OP_SUB   = 3'b001,
    OP_MUL   = 3'b010,
    OP_MADD  = 3'b100,
    OP_MSUB  = 3'b101,
    OP_NMSUB = 3'b110,
    OP_NMADD = 3'b111
  } mac_op_e;

  // one two's-complement data word
  typedef logic [`MAC_DATA_W-1:0] word_t;

  // operands as issued at the unit input
  typedef struct packed {
    mac_op_e op;
    word_t   a;
    word_t   b;
    word_t   c;
  } operand_rec_t;

  // multiplier to adder hand-off
  // prod wraps modulo 2^MAC_DATA_W
  typedef struct packed {
    mac_op_e op;
    word_t   prod;
    word_t   addend;
  } product_rec_t;

endpackage

`default_nettype wire

// ==== rtl/stream_fifo.sv ====
`default_nettype none
`timescale 1ns/1ps

module stream_fifo
  import mac_pkg::*;
#(
  parameter type payload_t = word_t
) (
  input  wire      clk,
  input  wire      reset_i,
  input  wire      w_valid_i,
  output logic     w_ready_o,
  input  payload_t w_data_i,
  output logic     r_valid_o,
  input  wire      r_ready_i,
  output payload_t r_data_o
);

  logic     full;
  payload_t entry;

  // room when empty or when the entry drains this cycle
  assign w_ready_o = !full || r_ready_i;
  assign r_valid_o = full;
  assign r_data_o  = entry;

  // occupancy flag
  always_ff @(posedge clk) begin
    if (reset_i) begin
      full <= 1'b0;
    end else if (w_valid_i && w_ready_o) begin
      full <= 1'b1;
    end else if (r_ready_i) begin
      full <= 1'b0;
    end
  end

  // payload register
  always_ff @(posedge clk) begin
    if (w_valid_i && w_ready_o) begin
      entry <= w_data_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mul_pipe.sv ====
`default_nettype none
`timescale 1ns/1ps

module mul_pipe
  import mac_pkg::*;
(
  input  wire          clk,
  input  wire          reset_i,
  input  wire          in_valid_i,
  output logic         in_ready_o,
  input  operand_rec_t in_rec_i,
  output logic         out_valid_o,
  input  wire          out_ready_i,
  output product_rec_t out_rec_o
);

  // stage one, registered operands
  logic         s1_valid;
  operand_rec_t s1_rec;
  logic         s1_ready;

  // stage two, registered product record
  logic         s2_valid;
  product_rec_t s2_rec;
  logic         s2_ready;

  // a stage moves when the next one is empty or moving
  assign s2_ready   = !s2_valid || out_ready_i;
  assign s1_ready   = !s1_valid || s2_ready;
  assign in_ready_o = s1_ready;

  assign out_valid_o = s2_valid;
  assign out_rec_o   = s2_rec;

  // valid flags
  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= in_valid_i;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  // data path
  always_ff @(posedge clk) begin
    if (in_valid_i && s1_ready) begin
      s1_rec <= in_rec_i;
    end
    if (s1_valid && s2_ready) begin
      s2_rec.op     <= s1_rec.op;
      // low half of the product only
      s2_rec.prod   <= s1_rec.a * s1_rec.b;
      s2_rec.addend <= s1_rec.c;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/add_pipe.sv ====
`default_nettype none
`timescale 1ns/1ps

module add_pipe
  import mac_pkg::*;
(
  input  wire          clk,
  input  wire          reset_i,
  input  wire          in_valid_i,
  output logic         in_ready_o,
  input  product_rec_t in_rec_i,
  output logic         out_valid_o,
  input  wire          out_ready_i,
  output word_t        out_sum_o
);

  // sign choices from the op code
  // op[0] negates the addend, op[2] with op[1] negates the product
  logic  neg_prod;
  logic  neg_addend;
  word_t x_in;
  word_t y_in;

  // stage one, signed terms
  logic  s1_valid;
  word_t s1_x;
  word_t s1_y;
  logic  s1_ready;

  // stage two, wrapped sum
  logic  s2_valid;
  word_t s2_sum;
  logic  s2_ready;

  assign neg_prod   = in_rec_i.op[2] && in_rec_i.op[1];
  assign neg_addend = in_rec_i.op[0];
  assign x_in       = neg_prod ? -in_rec_i.prod : in_rec_i.prod;
  assign y_in       = neg_addend ? -in_rec_i.addend : in_rec_i.addend;

  // stall chain
  assign s2_ready   = !s2_valid || out_ready_i;
  assign s1_ready   = !s1_valid || s2_ready;
  assign in_ready_o = s1_ready;

  assign out_valid_o = s2_valid;
  assign out_sum_o   = s2_sum;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_ready) begin
        s1_valid <= in_valid_i;
      end
      if (s2_ready) begin
        s2_valid <= s1_valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid_i && s1_ready) begin
      s1_x <= x_in;
      s1_y <= y_in;
    end
    // carry out dropped, sum wraps
    if (s1_valid && s2_ready) begin
      s2_sum <= s1_x + s1_y;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/op_dispatch.sv ====
`default_nettype none
`timescale 1ns/1ps

module op_dispatch
  import mac_pkg::*;
(
  input  wire          in_valid_i,
  output logic         in_ready_o,
  input  operand_rec_t in_rec_i,
  output logic         mul_valid_o,
  input  wire          mul_ready_i,
  output logic         direct_valid_o,
  input  wire          direct_ready_i,
  input  wire          prod_valid_i,
  output logic         prod_ready_o,
  input  product_rec_t prod_rec_i,
  output logic         fused_valid_o,
  input  wire          fused_ready_i,
  output logic         mulres_valid_o,
  input  wire          mulres_ready_i,
  output word_t        mulres_word_o
);

  logic is_fused;
  logic is_mul;
  logic is_addsub;
  logic prod_fused;

  // input decode, reserved 011 matches none of these
  assign is_fused  = in_rec_i.op[2];
  assign is_mul    = in_rec_i.op == OP_MUL;
  assign is_addsub = in_rec_i.op[2:1] == 2'b00;

  // exactly one path sees the valid
  assign mul_valid_o    = in_valid_i && (is_fused || is_mul);
  assign direct_valid_o = in_valid_i && is_addsub;

  // ready follows the chosen path, low for the reserved code
  assign in_ready_o = is_addsub           ? direct_ready_i :
                      (is_fused || is_mul) ? mul_ready_i    : 1'b0;

  // product split, fused goes on to the adder
  assign prod_fused     = prod_rec_i.op[2];
  assign fused_valid_o  = prod_valid_i && prod_fused;
  assign mulres_valid_o = prod_valid_i && !prod_fused;
  assign mulres_word_o  = prod_rec_i.prod;
  assign prod_ready_o   = prod_fused ? fused_ready_i : mulres_ready_i;

endmodule

`default_nettype wire

// ==== rtl/add_input_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module add_input_arbiter
  import mac_pkg::*;
(
  input  wire          clk,
  input  wire          reset_i,
  input  wire          fused_valid_i,
  output logic         fused_ready_o,
  input  product_rec_t fused_rec_i,
  input  wire          direct_valid_i,
  output logic         direct_ready_o,
  input  operand_rec_t direct_rec_i,
  output logic         add_valid_o,
  input  wire          add_ready_i,
  output product_rec_t add_rec_o
);

  logic         fq_valid;
  logic         fq_ready;
  product_rec_t fq_rec;
  logic         dq_valid;
  logic         dq_ready;
  operand_rec_t dq_rec;
  product_rec_t dq_as_prod;

  // fused hand-off from the multiplier
  stream_fifo #(.payload_t(product_rec_t)) u_fused_q (
    .clk      (clk),
    .reset_i  (reset_i),
    .w_valid_i(fused_valid_i),
    .w_ready_o(fused_ready_o),
    .w_data_i (fused_rec_i),
    .r_valid_o(fq_valid),
    .r_ready_i(fq_ready),
    .r_data_o (fq_rec)
  );

  // add and sub straight from the input
  stream_fifo #(.payload_t(operand_rec_t)) u_direct_q (
    .clk      (clk),
    .reset_i  (reset_i),
    .w_valid_i(direct_valid_i),
    .w_ready_o(direct_ready_o),
    .w_data_i (direct_rec_i),
    .r_valid_o(dq_valid),
    .r_ready_i(dq_ready),
    .r_data_o (dq_rec)
  );

  // a rides in the product slot, b in the addend
  assign dq_as_prod = '{op: dq_rec.op, prod: dq_rec.a, addend: dq_rec.b};

  // fused wins whenever it holds an entry
  assign fq_ready    = add_ready_i;
  assign dq_ready    = !fq_valid && add_ready_i;
  assign add_valid_o = fq_valid || dq_valid;
  assign add_rec_o   = fq_valid ? fq_rec : dq_as_prod;

endmodule

`default_nettype wire

// ==== rtl/result_arbiter.sv ====
`default_nettype none
`timescale 1ns/1ps

module result_arbiter
  import mac_pkg::*;
(
  input  wire   clk,
  input  wire   reset_i,
  input  wire   mul_valid_i,
  output logic  mul_ready_o,
  input  word_t mul_word_i,
  input  wire   add_valid_i,
  output logic  add_ready_o,
  input  word_t add_word_i,
  output logic  out_valid_o,
  input  wire   out_ready_i,
  output word_t out_result_o
);

  logic  mq_valid;
  logic  mq_ready;
  word_t mq_word;
  logic  aq_valid;
  logic  aq_ready;
  word_t aq_word;

  // multiplier-only results
  stream_fifo #(.payload_t(word_t)) u_mul_q (
    .clk      (clk),
    .reset_i  (reset_i),
    .w_valid_i(mul_valid_i),
    .w_ready_o(mul_ready_o),
    .w_data_i (mul_word_i),
    .r_valid_o(mq_valid),
    .r_ready_i(mq_ready),
    .r_data_o (mq_word)
  );

  // adder results, direct and fused
  stream_fifo #(.payload_t(word_t)) u_add_q (
    .clk      (clk),
    .reset_i  (reset_i),
    .w_valid_i(add_valid_i),
    .w_ready_o(add_ready_o),
    .w_data_i (add_word_i),
    .r_valid_o(aq_valid),
    .r_ready_i(aq_ready),
    .r_data_o (aq_word)
  );

  // mul buffer first, adder only when mul buffer is empty
  assign mq_ready     = out_ready_i;
  assign aq_ready     = !mq_valid && out_ready_i;
  assign out_valid_o  = mq_valid || aq_valid;
  assign out_result_o = mq_valid ? mq_word : aq_word;

endmodule

`default_nettype wire

// ==== rtl/mac_unit_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module mac_unit_top
  import mac_pkg::*;
(
  input  wire     clk,
  input  wire     reset_i,
  input  wire     in_valid_i,
  output logic    in_ready_o,
  input  mac_op_e in_op_i,
  input  word_t   in_a_i,
  input  word_t   in_b_i,
  input  word_t   in_c_i,
  output logic    out_valid_o,
  input  wire     out_ready_i,
  output word_t   out_result_o
);

  operand_rec_t in_rec;

  // dispatch to multiplier or direct adder flow
  logic         mul_in_valid;
  logic         mul_in_ready;
  logic         direct_valid;
  logic         direct_ready;

  // multiplier output and its split
  logic         prod_valid;
  logic         prod_ready;
  product_rec_t prod_rec;
  logic         fused_valid;
  logic         fused_ready;
  logic         mulres_valid;
  logic         mulres_ready;
  word_t        mulres_word;

  // adder input and output
  logic         add_valid;
  logic         add_ready;
  product_rec_t add_rec;
  logic         sum_valid;
  logic         sum_ready;
  word_t        sum_word;

  assign in_rec = '{op: in_op_i, a: in_a_i, b: in_b_i, c: in_c_i};

  op_dispatch u_dispatch (
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_rec_i      (in_rec),
    .mul_valid_o   (mul_in_valid),
    .mul_ready_i   (mul_in_ready),
    .direct_valid_o(direct_valid),
    .direct_ready_i(direct_ready),
    .prod_valid_i  (prod_valid),
    .prod_ready_o  (prod_ready),
    .prod_rec_i    (prod_rec),
    .fused_valid_o (fused_valid),
    .fused_ready_i (fused_ready),
    .mulres_valid_o(mulres_valid),
    .mulres_ready_i(mulres_ready),
    .mulres_word_o (mulres_word)
  );

  mul_pipe u_mul (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (mul_in_valid),
    .in_ready_o (mul_in_ready),
    .in_rec_i   (in_rec),
    .out_valid_o(prod_valid),
    .out_ready_i(prod_ready),
    .out_rec_o  (prod_rec)
  );

  // fused records come straight off the multiplier
  add_input_arbiter u_add_arb (
    .clk           (clk),
    .reset_i       (reset_i),
    .fused_valid_i (fused_valid),
    .fused_ready_o (fused_ready),
    .fused_rec_i   (prod_rec),
    .direct_valid_i(direct_valid),
    .direct_ready_o(direct_ready),
    .direct_rec_i  (in_rec),
    .add_valid_o   (add_valid),
    .add_ready_i   (add_ready),
    .add_rec_o     (add_rec)
  );

  add_pipe u_add (
    .clk        (clk),
    .reset_i    (reset_i),
    .in_valid_i (add_valid),
    .in_ready_o (add_ready),
    .in_rec_i   (add_rec),
    .out_valid_o(sum_valid),
    .out_ready_i(sum_ready),
    .out_sum_o  (sum_word)
  );

  result_arbiter u_res_arb (
    .clk         (clk),
    .reset_i     (reset_i),
    .mul_valid_i (mulres_valid),
    .mul_ready_o (mulres_ready),
    .mul_word_i  (mulres_word),
    .add_valid_i (sum_valid),
    .add_ready_o (sum_ready),
    .add_word_i  (sum_word),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_result_o(out_result_o)
  );

endmodule

`default_nettype wire

// ==== bench/mac_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module mac_checker
  import mac_pkg::*;
(
  input  wire     clk,
  input  wire     reset_i,
  input  wire     in_valid_i,
  input  wire     in_ready_i,
  input  mac_op_e in_op_i,
  input  word_t   in_a_i,
  input  word_t   in_b_i,
  input  word_t   in_c_i,
  input  wire     out_valid_i,
  input  wire     out_ready_i,
  input  word_t   out_result_i,
  input  int      test_id_i,
  input  wire     test_end_i,
  output int      pending_o,
  output int      tests_ok_o,
  output int      tests_bad_o
);

  // mul results keep issue order
  // the rest may overtake each other
  word_t mul_q[$];
  int    other_cnt[word_t];
  int    other_total;
  int    errors;
  int    checked;

  function automatic string test_label(input int id);
    case (id)
      0: return "reset_idle";
      1: return "add_sub";
      2: return "mul_only";
      3: return "fused";
      default: return "mixed_backpressure";
    endcase
  endfunction

  // reference model with all arithmetic wrapping at the word width
  function automatic word_t model_result(
    input mac_op_e op,
    input word_t   a,
    input word_t   b,
    input word_t   c
  );
    word_t p;
    p = a * b;
    case (op)
      OP_ADD:   return a + b;
      OP_SUB:   return a - b;
      OP_MUL:   return p;
      OP_MADD:  return p + c;
      OP_MSUB:  return p - c;
      OP_NMSUB: return c - p;
      OP_NMADD: return word_t'(0) - p - c;
      default:  return '0;
    endcase
  endfunction

  task automatic add_expected(input mac_op_e op, input word_t a, input word_t b, input word_t c);
    word_t want;
    want = model_result(op, a, b, c);
    if (op == OP_MUL) begin
      mul_q.push_back(want);
    end else begin
      if (other_cnt.exists(want)) begin
        other_cnt[want] = other_cnt[want] + 1;
      end else begin
        other_cnt[want] = 1;
      end
      other_total = other_total + 1;
    end
  endtask

  // drop one copy of a pending adder-side result
  task automatic take_other(input word_t key);
    other_cnt[key] = other_cnt[key] - 1;
    if (other_cnt[key] == 0) begin
      other_cnt.delete(key);
    end
    other_total = other_total - 1;
  endtask

  task automatic check_result(input word_t got);
    word_t want;
    checked = checked + 1;
    if (mul_q.size() > 0 && mul_q[0] == got) begin
      void'(mul_q.pop_front());
    end else if (other_cnt.exists(got)) begin
      take_other(got);
    end else if (mul_q.size() > 0) begin
      want   = mul_q.pop_front();
      errors = errors + 1;
      $display("mismatch in %s: expected %08h, actual %08h", test_label(test_id_i), want, got);
    end else if (other_total > 0) begin
      // with no exact match the lowest pending key takes the blame
      void'(other_cnt.first(want));
      take_other(want);
      errors = errors + 1;
      $display("mismatch in %s: expected %08h, actual %08h", test_label(test_id_i), want, got);
    end else begin
      errors = errors + 1;
      $display("%s: result %08h came out with no operation outstanding",
               test_label(test_id_i), got);
    end
  endtask

  task automatic close_test();
    int left;
    left = mul_q.size() + other_total;
    if (left != 0) begin
      errors = errors + 1;
      $display("%s: %0d results still outstanding after drain", test_label(test_id_i), left);
      mul_q.delete();
      other_cnt.delete();
      other_total = 0;
    end
    $display("%s: %0d results checked, %0d errors", test_label(test_id_i), checked, errors);
    if (errors == 0) begin
      tests_ok_o = tests_ok_o + 1;
    end else begin
      tests_bad_o = tests_bad_o + 1;
    end
    errors  = 0;
    checked = 0;
  endtask

  // handshakes sampled at the rising edge like a flop
  always @(posedge clk) begin
    if (reset_i) begin
      mul_q.delete();
      other_cnt.delete();
      other_total = 0;
      errors      = 0;
      checked     = 0;
      tests_ok_o  = 0;
      tests_bad_o = 0;
    end else begin
      if (in_valid_i && in_ready_i) begin
        add_expected(in_op_i, in_a_i, in_b_i, in_c_i);
      end
      if (out_valid_i && out_ready_i) begin
        check_result(out_result_i);
      end
      if (test_end_i) begin
        close_test();
      end
    end
    pending_o = mul_q.size() + other_total;
  end

endmodule

`default_nettype wire

// ==== bench/mac_unit_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module mac_unit_tb
  import mac_pkg::*;
();

  localparam int OPS_PER_TEST   = 100;
  localparam int TEST_COUNT     = 4;
  localparam int SEED           = 96;
  localparam int RESET_CYCLES   = 16;
  localparam int DRAIN_LIMIT    = 200;
  // about eight cycles per op at worst, plus reset and drain slack
  localparam int TIMEOUT_CYCLES = TEST_COUNT * OPS_PER_TEST * 8 + 200;

  logic    clk = 1'b0;
  logic    reset_i;
  logic    in_valid_i;
  logic    in_ready_o;
  mac_op_e in_op_i;
  word_t   in_a_i;
  word_t   in_b_i;
  word_t   in_c_i;
  logic    out_valid_o;
  logic    out_ready_i = 1'b1;
  word_t   out_result_o;

  // test control and checker status
  int      test_id;
  logic    test_end;
  logic    backpressure;
  int      pending;
  int      tests_ok;
  int      tests_bad;
  int      stall_roll = 0;
  int      cycle_count = 0;

  always #5 clk = ~clk;

  mac_unit_top uut (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_op_i     (in_op_i),
    .in_a_i      (in_a_i),
    .in_b_i      (in_b_i),
    .in_c_i      (in_c_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_result_o(out_result_o)
  );

  mac_checker chk (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_ready_i  (in_ready_o),
    .in_op_i     (in_op_i),
    .in_a_i      (in_a_i),
    .in_b_i      (in_b_i),
    .in_c_i      (in_c_i),
    .out_valid_i (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_result_i(out_result_o),
    .test_id_i   (test_id),
    .test_end_i  (test_end),
    .pending_o   (pending),
    .tests_ok_o  (tests_ok),
    .tests_bad_o (tests_bad)
  );

  // stall roll drawn on the rising edge, applied on the falling edge
  always @(posedge clk) begin
    stall_roll <= $urandom_range(99);
  end

  // roughly 30% stalls on the result side under backpressure
  always @(negedge clk) begin
    out_ready_i = !backpressure || (stall_roll >= 30);
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  // op mix per test, never the reserved code
  function automatic mac_op_e pick_op(input int id);
    int r;
    case (id)
      1: r = $urandom_range(1);
      2: r = 2;
      3: r = $urandom_range(6, 3);
      default: r = $urandom_range(6);
    endcase
    case (r)
      0: return OP_ADD;
      1: return OP_SUB;
      2: return OP_MUL;
      3: return OP_MADD;
      4: return OP_MSUB;
      5: return OP_NMSUB;
      default: return OP_NMADD;
    endcase
  endfunction

  // entered and left on a falling edge
  task automatic issue_op(input int id);
    int gap;
    if (id == 4 && $urandom_range(3) == 0) begin
      gap        = $urandom_range(3, 1);
      in_valid_i = 1'b0;
      repeat (gap) @(negedge clk);
    end
    in_op_i    = pick_op(id);
    in_a_i     = $urandom();
    in_b_i     = $urandom();
    in_c_i     = $urandom();
    in_valid_i = 1'b1;
    // hold until accepted
    @(posedge clk);
    while (!in_ready_o) begin
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  task automatic run_test(input int id);
    int waited;
    @(posedge clk);
    backpressure = (id == 4);
    @(negedge clk);
    test_id = id;
    if (id > 0) begin
      repeat (OPS_PER_TEST) issue_op(id);
    end else begin
      // idle window, out_valid_o must stay low
      repeat (8) @(negedge clk);
    end
    in_valid_i = 1'b0;
    @(posedge clk);
    backpressure = 1'b0;
    waited       = 0;
    while (pending != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited = waited + 1;
    end
    @(negedge clk);
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  initial begin
    void'($urandom(SEED));
    reset_i      = 1'b1;
    in_valid_i   = 1'b0;
    in_op_i      = OP_ADD;
    in_a_i       = '0;
    in_b_i       = '0;
    in_c_i       = '0;
    test_id      = 0;
    test_end     = 1'b0;
    backpressure = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_i = 1'b0;
    // id 0 is the post-reset idle check, then the four op tests
    for (int t = 0; t <= TEST_COUNT; t++) begin
      run_test(t);
    end
    @(negedge clk);
    $display("summary: %0d tests clean, %0d tests with errors", tests_ok, tests_bad);
    if (tests_bad == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/mac_pkg.sv
rtl/stream_fifo.sv
rtl/mul_pipe.sv
rtl/add_pipe.sv
rtl/op_dispatch.sv
rtl/add_input_arbiter.sv
rtl/result_arbiter.sv
rtl/mac_unit_top.sv
bench/mac_checker.sv
bench/mac_unit_tb.sv

// ==== Makefile ====
# testbench top for simulation, RTL top for a design-only lint pass
TB_TOP  = mac_unit_tb
RTL_TOP = mac_unit_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f list.f --top-module $(RTL_TOP)
	verilator --lint-only --timing -f list.f --top-module $(TB_TOP)

# status comes from the pass line in the simulator output
sim:
	verilator --binary --timing -f list.f --top-module $(TB_TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir
